//--- Makefile
# Verilator build and run for the LSU control stage

VERILATOR ?= verilator
TOP       ?= tb_lsu_ctrl
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- lsu_cmd_split.sv
////////////////////////////////////////
// Splits AGU commands between DTCM and BIU
// Accept needs both targets ready, a simplification
// Never mixes targets while anything is outstanding
////////////////////////////////////////
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_cmd_split (
  input  logic                    i_agu_cmd_valid,
  input  lsu_pkg::lsu_cmd_t       i_agu_cmd,
  input  logic [`LSU_ADDR_W-1:0]  i_dtcm_region,
  input  logic                    i_dtcm_cmd_ready,
  input  logic                    i_biu_cmd_ready,
  input  logic                    i_outs_full,
  input  logic                    i_outs_empty,
  input  logic                    i_outs_head_dtcm,
  input  logic                    i_scond_ok,
  output logic                    o_agu_cmd_ready,
  output logic                    o_dtcm_cmd_valid,
  output lsu_pkg::tgt_cmd_t       o_dtcm_cmd,
  output logic                    o_biu_cmd_valid,
  output lsu_pkg::tgt_cmd_t       o_biu_cmd,
  output logic                    o_push,
  output lsu_pkg::outs_rec_t      o_push_rec
);
  import lsu_pkg::*;

  logic     to_dtcm;
  logic     diff_tgt;
  logic     slot_ok;
  logic     scond;
  tgt_cmd_t tgt_cmd;

  ////////////////////////////////////////
  // Target decode and issue gating
  ////////////////////////////////////////
  assign to_dtcm = (i_agu_cmd.addr[`LSU_DTCM_RGN_HI:`LSU_DTCM_RGN_LO] ==
                    i_dtcm_region[`LSU_DTCM_RGN_HI:`LSU_DTCM_RGN_LO]);

  // Head of the table tells which target owns the traffic in flight
  assign diff_tgt = ~i_outs_empty & (i_outs_head_dtcm != to_dtcm);

  assign slot_ok = i_agu_cmd_valid & ~i_outs_full & ~diff_tgt;

  // Ready only offered against a pending command
  assign o_agu_cmd_ready = slot_ok & i_dtcm_cmd_ready & i_biu_cmd_ready;

  // Each valid waits on the other target's ready, never on its own
  assign o_dtcm_cmd_valid = slot_ok & to_dtcm & i_biu_cmd_ready;
  assign o_biu_cmd_valid  = slot_ok & ~to_dtcm & i_dtcm_cmd_ready;

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////
  assign scond = i_agu_cmd.excl & ~i_agu_cmd.read;

  always_comb begin
    tgt_cmd.addr  = i_agu_cmd.addr;
    tgt_cmd.read  = i_agu_cmd.read;
    tgt_cmd.wdata = i_agu_cmd.wdata;
    tgt_cmd.size  = i_agu_cmd.size;
    // Failed store-conditional still goes out, but writes nothing
    if (scond & ~i_scond_ok) begin
      tgt_cmd.wmask = '0;
    end else begin
      tgt_cmd.wmask = i_agu_cmd.wmask;
    end
  end

  assign o_dtcm_cmd = tgt_cmd;
  assign o_biu_cmd  = tgt_cmd;

  // One table entry per accepted command
  assign o_push = i_agu_cmd_valid & o_agu_cmd_ready;

  always_comb begin
    o_push_rec.to_dtcm  = to_dtcm;
    o_push_rec.scond_ok = i_scond_ok;
    o_push_rec.read     = i_agu_cmd.read;
    o_push_rec.excl     = i_agu_cmd.excl;
    o_push_rec.size     = i_agu_cmd.size;
    o_push_rec.usign    = i_agu_cmd.usign;
    o_push_rec.itag     = i_agu_cmd.itag;
    o_push_rec.addr     = i_agu_cmd.addr;
  end

endmodule

//--- lsu_ctrl_assert.sv
////////////////////////////////////////
// Protocol checks on the LSU control top
// Sampled on the rising clock edge
////////////////////////////////////////
`timescale 1ns/10ps

module lsu_ctrl_assert (
  input logic clk,
  input logic i_reset,
  input logic o_dtcm_cmd_valid,
  input logic o_biu_cmd_valid,
  input logic o_wbck_valid,
  input logic i_outs_empty,
  input logic o_ctrl_active
);

  // Only one target gets a command at a time
  property one_target_cmd;
    @(posedge clk) disable iff (i_reset)
      !(o_dtcm_cmd_valid && o_biu_cmd_valid);
  endproperty

  // A write-back always belongs to a table entry
  property wbck_needs_entry;
    @(posedge clk) disable iff (i_reset)
      o_wbck_valid |-> !i_outs_empty;
  endproperty

  // Idle while reset is held
  property idle_in_reset;
    @(posedge clk)
      (i_reset && $past(i_reset)) |-> !o_ctrl_active;
  endproperty

  a_one_target_cmd: assert property (one_target_cmd)
    else $error("DTCM and BIU command valids are high together");

  a_wbck_needs_entry: assert property (wbck_needs_entry)
    else $error("write-back valid while the outstanding table is empty");

  a_idle_in_reset: assert property (idle_in_reset)
    else $error("ctrl_active is high during reset");

endmodule

//--- lsu_ctrl_top.sv
////////////////////////////////////////
// LSU control stage, single AGU requester
// Targets must answer in order, at least one cycle after accept
////////////////////////////////////////
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_ctrl_top (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_agu_cmd_valid,
  output logic                    o_agu_cmd_ready,
  input  lsu_pkg::lsu_cmd_t       i_agu_cmd,
  output logic                    o_dtcm_cmd_valid,
  input  logic                    i_dtcm_cmd_ready,
  output lsu_pkg::tgt_cmd_t       o_dtcm_cmd,
  input  logic                    i_dtcm_rsp_valid,
  output logic                    o_dtcm_rsp_ready,
  input  lsu_pkg::tgt_rsp_t       i_dtcm_rsp,
  output logic                    o_biu_cmd_valid,
  input  logic                    i_biu_cmd_ready,
  output lsu_pkg::tgt_cmd_t       o_biu_cmd,
  input  logic                    i_biu_rsp_valid,
  output logic                    o_biu_rsp_ready,
  input  lsu_pkg::tgt_rsp_t       i_biu_rsp,
  output logic                    o_wbck_valid,
  input  logic                    i_wbck_ready,
  output lsu_pkg::wbck_t          o_wbck,
  input  logic [`LSU_ADDR_W-1:0]  i_dtcm_region,
  input  logic                    i_commit_trap,
  input  logic                    i_commit_mret,
  output logic                    o_ctrl_active
);
  import lsu_pkg::*;

  logic      push;
  outs_rec_t push_rec;
  logic      pop;
  outs_rec_t head_rec;
  logic      outs_empty;
  logic      outs_full;
  logic      scond_ok;

  ////////////////////////////////////////
  // Command side
  ////////////////////////////////////////
  lsu_cmd_split u_cmd_split (
    .i_agu_cmd_valid  (i_agu_cmd_valid),
    .i_agu_cmd        (i_agu_cmd),
    .i_dtcm_region    (i_dtcm_region),
    .i_dtcm_cmd_ready (i_dtcm_cmd_ready),
    .i_biu_cmd_ready  (i_biu_cmd_ready),
    .i_outs_full      (outs_full),
    .i_outs_empty     (outs_empty),
    .i_outs_head_dtcm (head_rec.to_dtcm),
    .i_scond_ok       (scond_ok),
    .o_agu_cmd_ready  (o_agu_cmd_ready),
    .o_dtcm_cmd_valid (o_dtcm_cmd_valid),
    .o_dtcm_cmd       (o_dtcm_cmd),
    .o_biu_cmd_valid  (o_biu_cmd_valid),
    .o_biu_cmd        (o_biu_cmd),
    .o_push           (push),
    .o_push_rec       (push_rec)
  );

  lsu_excl_monitor u_excl_monitor (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_accept      (push),
    .i_cmd         (i_agu_cmd),
    .i_commit_trap (i_commit_trap),
    .i_commit_mret (i_commit_mret),
    .o_scond_ok    (scond_ok)
  );

  lsu_outs_fifo #(
    .DEPTH (`LSU_OUTS_NUM)
  ) u_outs_fifo (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_push     (push),
    .i_push_rec (push_rec),
    .i_pop      (pop),
    .o_head_rec (head_rec),
    .o_empty    (outs_empty),
    .o_full     (outs_full)
  );

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////
  lsu_rsp_wbck u_rsp_wbck (
    .i_head_rec       (head_rec),
    .i_empty          (outs_empty),
    .i_dtcm_rsp_valid (i_dtcm_rsp_valid),
    .i_dtcm_rsp       (i_dtcm_rsp),
    .i_biu_rsp_valid  (i_biu_rsp_valid),
    .i_biu_rsp        (i_biu_rsp),
    .i_wbck_ready     (i_wbck_ready),
    .o_dtcm_rsp_ready (o_dtcm_rsp_ready),
    .o_biu_rsp_ready  (o_biu_rsp_ready),
    .o_pop            (pop),
    .o_wbck_valid     (o_wbck_valid),
    .o_wbck           (o_wbck)
  );

  // Busy while a command waits or anything is in flight
  assign o_ctrl_active = i_agu_cmd_valid | ~outs_empty;

endmodule

//--- lsu_excl_monitor.sv
////////////////////////////////////////
// Single reservation for LR/SC
// Assumes one hart, no snooping of other masters
////////////////////////////////////////
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_excl_monitor (
  input  logic              clk,
  input  logic              i_reset,
  input  logic              i_accept,
  input  lsu_pkg::lsu_cmd_t i_cmd,
  input  logic              i_commit_trap,
  input  logic              i_commit_mret,
  output logic              o_scond_ok
);
  import lsu_pkg::*;

  logic                   excl_flg;
  logic [`LSU_ADDR_W-1:0] excl_addr;
  logic                   addr_hit;
  logic                   flg_set;
  logic                   flg_clr;

  assign addr_hit = (i_cmd.addr == excl_addr);

  // Load-reserved going out
  assign flg_set = i_accept & i_cmd.read & i_cmd.excl;

  // Any store to the reserved word kills it, so does a trap or mret
  assign flg_clr = (i_accept & ~i_cmd.read & addr_hit & excl_flg) |
                   i_commit_trap | i_commit_mret;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      excl_flg <= 1'b0;
    end else if (flg_set) begin
      excl_flg <= 1'b1;
    end else if (flg_clr) begin
      excl_flg <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (flg_set) begin
      excl_addr <= i_cmd.addr;
    end
  end

  // Verdict for the store-conditional being presented now
  assign o_scond_ok = i_cmd.excl & ~i_cmd.read & excl_flg & addr_hit;

endmodule

//--- lsu_outs_fifo.sv
////////////////////////////////////////
// In-order table of outstanding accesses
// Head reads as zero when empty
// Push while full is taken only with a pop
////////////////////////////////////////
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_outs_fifo #(
  parameter int DEPTH = `LSU_OUTS_NUM
) (
  input  logic               clk,
  input  logic               i_reset,
  input  logic               i_push,
  input  lsu_pkg::outs_rec_t i_push_rec,
  input  logic               i_pop,
  output lsu_pkg::outs_rec_t o_head_rec,
  output logic               o_empty,
  output logic               o_full
);
  import lsu_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  outs_rec_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_en;
  logic             pop_en;

  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));

  assign pop_en  = i_pop & ~o_empty;
  assign push_en = i_push & (~o_full | pop_en);

  always_ff @(posedge clk) begin
    if (push_en) begin
      mem[wr_ptr] <= i_push_rec;
    end
  end

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head fields steer the response mux, keep them quiet when empty
  assign o_head_rec = o_empty ? '0 : mem[rd_ptr];

endmodule

//--- lsu_params.svh
////////////////////////////////////////
// Build-time sizes of the LSU control stage
// Only one DTCM region, selected by an address bit range
// LSU_OUTS_NUM of 1 or more is supported
////////////////////////////////////////
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data path width, RV32 only
`define LSU_XLEN 32

// Byte mask width follows the data width
`define LSU_WMASK_W (`LSU_XLEN / 8)

// Full byte address width
`define LSU_ADDR_W 32

// Instruction tag carried through to write-back
`define LSU_ITAG_W 3

// Entries in the outstanding table
`define LSU_OUTS_NUM 2

// Address bits compared against the DTCM region input
`define LSU_DTCM_RGN_HI 31
`define LSU_DTCM_RGN_LO 16

`endif

//--- lsu_pkg.sv
////////////////////////////////////////
// Shared types of the LSU control stage
// Field widths come from the params header
////////////////////////////////////////
`include "lsu_params.svh"

package lsu_pkg;

  // Access size, encoded as in the AGU command
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } lsu_size_e;

  // Command as issued by the AGU
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0]  addr;
    logic                    read;
    logic [`LSU_XLEN-1:0]    wdata;
    logic [`LSU_WMASK_W-1:0] wmask;
    logic                    excl;
    lsu_size_e               size;
    logic                    usign;
    logic [`LSU_ITAG_W-1:0]  itag;
  } lsu_cmd_t;

  // Command as presented to the DTCM or the BIU
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0]  addr;
    logic                    read;
    logic [`LSU_XLEN-1:0]    wdata;
    logic [`LSU_WMASK_W-1:0] wmask;
    lsu_size_e               size;
  } tgt_cmd_t;

  typedef struct packed {
    logic                 err;
    logic [`LSU_XLEN-1:0] rdata;
  } tgt_rsp_t;

  // One outstanding transaction, to_dtcm clear means BIU
  typedef struct packed {
    logic                   to_dtcm;
    logic                   scond_ok;
    logic                   read;
    logic                   excl;
    lsu_size_e              size;
    logic                   usign;
    logic [`LSU_ITAG_W-1:0] itag;
    logic [`LSU_ADDR_W-1:0] addr;
  } outs_rec_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0]   wdat;
    logic [`LSU_ITAG_W-1:0] itag;
    logic                   err;
    logic [`LSU_ADDR_W-1:0] badaddr;
    logic                   ld;
  } wbck_t;

endpackage

//--- lsu_rsp_wbck.sv
////////////////////////////////////////
// Response select and load write-back
// Only the head's target may respond
// Plain stores write back zero data
////////////////////////////////////////
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_rsp_wbck (
  input  lsu_pkg::outs_rec_t i_head_rec,
  input  logic               i_empty,
  input  logic               i_dtcm_rsp_valid,
  input  lsu_pkg::tgt_rsp_t  i_dtcm_rsp,
  input  logic               i_biu_rsp_valid,
  input  lsu_pkg::tgt_rsp_t  i_biu_rsp,
  input  logic               i_wbck_ready,
  output logic               o_dtcm_rsp_ready,
  output logic               o_biu_rsp_ready,
  output logic               o_pop,
  output logic               o_wbck_valid,
  output lsu_pkg::wbck_t     o_wbck
);
  import lsu_pkg::*;

  logic                 sel_dtcm;
  logic                 sel_biu;
  logic                 rsp_valid;
  tgt_rsp_t             rsp;
  logic [`LSU_XLEN-1:0] rdata_algn;
  logic [`LSU_XLEN-1:0] load_data;
  logic [`LSU_XLEN-1:0] wdat;

  ////////////////////////////////////////
  // Target select from the head record
  ////////////////////////////////////////
  assign sel_dtcm = ~i_empty & i_head_rec.to_dtcm;
  assign sel_biu  = ~i_empty & ~i_head_rec.to_dtcm;

  always_comb begin
    rsp_valid = 1'b0;
    rsp       = '0;
    if (sel_dtcm) begin
      rsp_valid = i_dtcm_rsp_valid;
      rsp       = i_dtcm_rsp;
    end else if (sel_biu) begin
      rsp_valid = i_biu_rsp_valid;
      rsp       = i_biu_rsp;
    end
  end

  // Stall the target while write-back is blocked
  assign o_dtcm_rsp_ready = sel_dtcm & i_wbck_ready;
  assign o_biu_rsp_ready  = sel_biu & i_wbck_ready;

  assign o_wbck_valid = rsp_valid;
  assign o_pop        = rsp_valid & i_wbck_ready;

  ////////////////////////////////////////
  // Load alignment and extension
  ////////////////////////////////////////
  assign rdata_algn = rsp.rdata >> {i_head_rec.addr[1:0], 3'b000};

  always_comb begin
    case (i_head_rec.size)
      size_byte: begin
        load_data = {{(`LSU_XLEN - 8){~i_head_rec.usign & rdata_algn[7]}},
                     rdata_algn[7:0]};
      end
      size_half: begin
        load_data = {{(`LSU_XLEN - 16){~i_head_rec.usign & rdata_algn[15]}},
                     rdata_algn[15:0]};
      end
      default: begin
        load_data = rdata_algn;
      end
    endcase
  end

  always_comb begin
    if (i_head_rec.read) begin
      wdat = load_data;
    end else if (i_head_rec.excl) begin
      // SC result, 0 on success
      wdat = {{(`LSU_XLEN - 1){1'b0}}, ~i_head_rec.scond_ok};
    end else begin
      wdat = '0;
    end
  end

  always_comb begin
    o_wbck.wdat    = wdat;
    o_wbck.itag    = i_head_rec.itag;
    o_wbck.err     = rsp.err;
    o_wbck.badaddr = i_head_rec.addr;
    o_wbck.ld      = i_head_rec.read;
  end

endmodule

//--- sim.f
+incdir+.
lsu_pkg.sv
lsu_cmd_split.sv
lsu_excl_monitor.sv
lsu_outs_fifo.sv
lsu_rsp_wbck.sv
lsu_ctrl_top.sv
lsu_ctrl_assert.sv
tb_lsu_ctrl.sv

//--- tb_lsu_ctrl.sv
////////////////////////////////////////
// Testbench for the LSU control stage
// Memory models answer in order after 1 to 4 cycles
// Word index 0xEE in either region returns err
////////////////////////////////////////
`timescale 1ns/10ps
`include "lsu_params.svh"

module tb_lsu_ctrl;
  import lsu_pkg::*;

  localparam logic [31:0] DTCM_BASE = 32'h0001_0000;
  localparam logic [31:0] BIU_BASE  = 32'h8000_0000;
  localparam int          WAIT_MAX  = 200;

  typedef struct packed {
    int       due;
    tgt_rsp_t rsp;
  } pend_t;

  logic        clk;
  logic        i_reset;
  logic        agu_valid;
  logic        agu_ready;
  lsu_cmd_t    agu_cmd;
  logic [1:0]  cmd_valid;
  logic [1:0]  cmd_ready;
  tgt_cmd_t    cmd_bus [2];
  logic [1:0]  rsp_valid;
  logic [1:0]  rsp_ready;
  tgt_rsp_t    rsp_bus [2];
  logic        wbck_valid;
  logic        wbck_ready;
  wbck_t       wbck;
  logic [31:0] dtcm_region;
  logic        commit_trap;
  logic        commit_mret;
  logic        ctrl_active;

  // Reference image, model image and in-flight bookkeeping
  logic [31:0] ref_mem [logic [29:0]];
  logic [31:0] tgt_mem [logic [29:0]];
  pend_t       pend_q [2][$];
  tgt_cmd_t    exp_cmd_q [2][$];
  wbck_t       exp_wb_q [$];
  logic        resv_vld;
  logic [31:0] resv_addr;
  logic [2:0]  itag_cnt;
  logic        stall_en;
  int          cycle;
  int          wb_errs;
  int          cmd_errs;
  int          other_errs;
  string       test_name;

  // Index 0 is the DTCM, index 1 the BIU
  lsu_ctrl_top UUT (
    .clk              (clk),
    .i_reset          (i_reset),
    .i_agu_cmd_valid  (agu_valid),
    .o_agu_cmd_ready  (agu_ready),
    .i_agu_cmd        (agu_cmd),
    .o_dtcm_cmd_valid (cmd_valid[0]),
    .i_dtcm_cmd_ready (cmd_ready[0]),
    .o_dtcm_cmd       (cmd_bus[0]),
    .i_dtcm_rsp_valid (rsp_valid[0]),
    .o_dtcm_rsp_ready (rsp_ready[0]),
    .i_dtcm_rsp       (rsp_bus[0]),
    .o_biu_cmd_valid  (cmd_valid[1]),
    .i_biu_cmd_ready  (cmd_ready[1]),
    .o_biu_cmd        (cmd_bus[1]),
    .i_biu_rsp_valid  (rsp_valid[1]),
    .o_biu_rsp_ready  (rsp_ready[1]),
    .i_biu_rsp        (rsp_bus[1]),
    .o_wbck_valid     (wbck_valid),
    .i_wbck_ready     (wbck_ready),
    .o_wbck           (wbck),
    .i_dtcm_region    (dtcm_region),
    .i_commit_trap    (commit_trap),
    .i_commit_mret    (commit_mret),
    .o_ctrl_active    (ctrl_active)
  );

  bind lsu_ctrl_top lsu_ctrl_assert u_ctrl_assert (
    .clk              (clk),
    .i_reset          (i_reset),
    .o_dtcm_cmd_valid (o_dtcm_cmd_valid),
    .o_biu_cmd_valid  (o_biu_cmd_valid),
    .o_wbck_valid     (o_wbck_valid),
    .i_outs_empty     (outs_empty),
    .o_ctrl_active    (o_ctrl_active)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // Memory helpers
  ////////////////////////////////////////
  // Unwritten words hold a pattern of their whole address
  function automatic logic [31:0] fill_word(input logic [29:0] widx);
    return {2'b10, widx} ^ {widx[13:0], widx[29:12]};
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    if (ref_mem.exists(addr[31:2])) begin
      return ref_mem[addr[31:2]];
    end
    return fill_word(addr[31:2]);
  endfunction

  function automatic logic [31:0] tgt_read(input logic [31:0] addr);
    if (tgt_mem.exists(addr[31:2])) begin
      return tgt_mem[addr[31:2]];
    end
    return fill_word(addr[31:2]);
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                        input logic [3:0] mask);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic is_err_addr(input logic [31:0] addr);
    return addr[9:2] == 8'hee;
  endfunction

  function automatic logic [31:0] make_addr(input int t, input int widx, input int off);
    return (t == 0 ? DTCM_BASE : BIU_BASE) + 32'(widx * 4 + off);
  endfunction

  function automatic lsu_cmd_t make_cmd(input logic rd, input logic ex, input lsu_size_e sz,
                                        input logic us, input logic [31:0] addr,
                                        input logic [31:0] data);
    lsu_cmd_t c;
    c = '0;
    c.addr  = addr;
    c.read  = rd;
    c.excl  = ex;
    c.size  = sz;
    c.usign = us;
    c.wdata = data << {addr[1:0], 3'b000};
    case (sz)
      size_byte: c.wmask = 4'b0001 << addr[1:0];
      size_half: c.wmask = 4'b0011 << addr[1:0];
      default:   c.wmask = 4'b1111;
    endcase
    return c;
  endfunction

  // Expected write-back from the command, the reference image and the SC verdict
  function automatic wbck_t ref_wbck(input lsu_cmd_t c, input logic sc_ok);
    wbck_t       w;
    logic [31:0] word;
    word = ref_read(c.addr) >> {c.addr[1:0], 3'b000};
    w = '0;
    if (c.read) begin
      case (c.size)
        size_byte: w.wdat = c.usign ? {24'h0, word[7:0]} : {{24{word[7]}}, word[7:0]};
        size_half: w.wdat = c.usign ? {16'h0, word[15:0]} : {{16{word[15]}}, word[15:0]};
        default:   w.wdat = word;
      endcase
    end else if (c.excl) begin
      w.wdat = {31'h0, ~sc_ok};
    end
    w.itag    = c.itag;
    w.err     = is_err_addr(c.addr);
    w.badaddr = c.addr;
    w.ld      = c.read;
    return w;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_wbck(input string name, input wbck_t exp, input wbck_t act);
    if (act !== exp) begin
      wb_errs++;
      $display("mismatch %s write-back: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_cmd(input string name, input tgt_cmd_t exp, input tgt_cmd_t act);
    if (act !== exp) begin
      cmd_errs++;
      $display("mismatch %s target command: expected %h actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic send_cmd(input lsu_cmd_t cmd);
    lsu_cmd_t c;
    tgt_cmd_t tc;
    logic     hit;
    logic     sc_ok;
    logic     done;
    int       n;
    c = cmd;
    c.itag = itag_cnt;
    itag_cnt = itag_cnt + 3'd1;
    hit   = resv_vld && (c.addr == resv_addr);
    sc_ok = c.excl && !c.read && hit;
    exp_wb_q.push_back(ref_wbck(c, sc_ok));
    tc.addr  = c.addr;
    tc.read  = c.read;
    tc.wdata = c.wdata;
    tc.size  = c.size;
    tc.wmask = (c.excl && !c.read && !sc_ok) ? 4'h0 : c.wmask;
    exp_cmd_q[(c.addr[31:16] == DTCM_BASE[31:16]) ? 0 : 1].push_back(tc);
    if (!c.read) begin
      ref_mem[c.addr[31:2]] = merge(ref_read(c.addr), c.wdata, tc.wmask);
    end
    if (c.read && c.excl) begin
      resv_vld  = 1'b1;
      resv_addr = c.addr;
    end else if (!c.read && hit) begin
      resv_vld = 1'b0;
    end
    agu_cmd   = c;
    agu_valid = 1'b1;
    done = 1'b0;
    n = 0;
    while (!done && n < WAIT_MAX) begin
      @(negedge clk);
      done = agu_ready;
      n++;
    end
    if (!done) begin
      other_errs++;
      $display("%s: command at %h was not accepted in time", test_name, c.addr);
    end
    @(posedge clk);
    #1;
    agu_valid = 1'b0;
  endtask

  task automatic pulse_commit(input logic trap);
    commit_trap = trap;
    commit_mret = ~trap;
    resv_vld    = 1'b0;
    @(posedge clk);
    #1;
    commit_trap = 1'b0;
    commit_mret = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_wb_q.size() != 0 && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (exp_wb_q.size() != 0 || exp_cmd_q[0].size() != 0 || exp_cmd_q[1].size() != 0) begin
      other_errs++;
      $display("%s: outstanding traffic did not drain in time", test_name);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_idle(input string name);
    @(negedge clk);
    if ({ctrl_active, agu_ready, wbck_valid, cmd_valid} !== 5'b0) begin
      other_errs++;
      $display("mismatch %s idle outputs: expected 00000 actual %b", name,
               {ctrl_active, agu_ready, wbck_valid, cmd_valid});
    end
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////
  // Target models
  ////////////////////////////////////////
  task automatic accept_cmd(input int t, input tgt_cmd_t c);
    pend_t p;
    if (pend_q[1-t].size() != 0) begin
      other_errs++;
      $display("%s: target %0d got a command while the other was busy", test_name, t);
    end
    if (exp_cmd_q[t].size() == 0) begin
      other_errs++;
      $display("%s: target %0d got an unexpected command", test_name, t);
    end else begin
      check_cmd(test_name, exp_cmd_q[t].pop_front(), c);
    end
    p.rsp.err   = is_err_addr(c.addr);
    p.rsp.rdata = tgt_read(c.addr);
    if (!c.read) begin
      tgt_mem[c.addr[31:2]] = merge(tgt_read(c.addr), c.wdata, c.wmask);
    end
    p.due = cycle + int'($urandom_range(3));
    pend_q[t].push_back(p);
  endtask

  initial begin : tgt_models
    logic [1:0] acc;
    logic [1:0] done;
    tgt_cmd_t   snap [2];
    cycle      = 0;
    cmd_ready  = 2'b00;
    rsp_valid  = 2'b00;
    rsp_bus[0] = '0;
    rsp_bus[1] = '0;
    forever begin
      // Handshakes are final by the falling edge
      @(negedge clk);
      acc  = cmd_valid & cmd_ready;
      done = rsp_valid & rsp_ready;
      snap[0] = cmd_bus[0];
      snap[1] = cmd_bus[1];
      @(posedge clk);
      #1;
      cycle++;
      for (int t = 0; t < 2; t++) begin
        if (done[t]) begin
          void'(pend_q[t].pop_front());
        end
      end
      for (int t = 0; t < 2; t++) begin
        if (acc[t]) begin
          accept_cmd(t, snap[t]);
        end
        if (pend_q[t].size() != 0 && pend_q[t][0].due <= cycle) begin
          rsp_valid[t] = 1'b1;
          rsp_bus[t]   = pend_q[t][0].rsp;
        end else begin
          rsp_valid[t] = 1'b0;
        end
        cmd_ready[t] = i_reset ? 1'b0 : ($urandom_range(3) != 0);
      end
    end
  end

  initial begin : wbck_ready_drv
    wbck_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      wbck_ready = stall_en ? ($urandom_range(3) != 0) : 1'b1;
    end
  end

  initial begin : wbck_compare
    forever begin
      @(negedge clk);
      if (wbck_valid && wbck_ready) begin
        if (exp_wb_q.size() == 0) begin
          other_errs++;
          $display("%s: write-back with nothing outstanding", test_name);
        end else begin
          check_wbck(test_name, exp_wb_q.pop_front(), wbck);
        end
      end
    end
  end

  // Busy while a command is offered or an accepted command still owes its write-back
  initial begin : active_compare
    int   outs_cnt;
    logic exp_act;
    outs_cnt = 0;
    forever begin
      @(negedge clk);
      if (!i_reset) begin
        exp_act = agu_valid || (outs_cnt != 0);
        if (ctrl_active !== exp_act) begin
          other_errs++;
          $display("mismatch %s ctrl_active: expected %b actual %b", test_name,
                   exp_act, ctrl_active);
        end
        outs_cnt = outs_cnt + int'(agu_valid && agu_ready) - int'(wbck_valid && wbck_ready);
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin : main
    int          off;
    int          sz;
    int          t;
    logic        ex;
    logic [31:0] a;
    void'($urandom(32'hf2975204));
    i_reset     = 1'b1;
    agu_valid   = 1'b0;
    agu_cmd     = '0;
    dtcm_region = DTCM_BASE;
    commit_trap = 1'b0;
    commit_mret = 1'b0;
    stall_en    = 1'b0;
    resv_vld    = 1'b0;
    resv_addr   = '0;
    itag_cnt    = '0;
    wb_errs     = 0;
    cmd_errs    = 0;
    other_errs  = 0;
    test_name   = "reset";
    repeat (3) @(posedge clk);
    #1;
    i_reset = 1'b0;
    check_idle("reset");

    // Every size, sign and legal offset in both regions
    test_name = "load_align";
    for (t = 0; t < 2; t++) begin
      send_cmd(make_cmd(1'b0, 1'b0, size_word, 1'b0, make_addr(t, 3, 0), 32'h80ff_7f01));
      for (sz = 0; sz < 3; sz++) begin
        for (off = 0; off < 4; off += (sz == 0) ? 1 : (sz == 1) ? 2 : 4) begin
          send_cmd(make_cmd(1'b1, 1'b0, lsu_size_e'(2'(sz)), 1'b0, make_addr(t, 3, off), 0));
          send_cmd(make_cmd(1'b1, 1'b0, lsu_size_e'(2'(sz)), 1'b1, make_addr(t, 3, off), 0));
        end
      end
    end
    drain();

    test_name = "store";
    for (t = 0; t < 2; t++) begin
      for (sz = 0; sz < 3; sz++) begin
        for (off = 0; off < 4; off += (sz == 0) ? 1 : (sz == 1) ? 2 : 4) begin
          send_cmd(make_cmd(1'b0, 1'b0, lsu_size_e'(2'(sz)), 1'b0, make_addr(t, 5, off),
                            $urandom()));
          send_cmd(make_cmd(1'b1, 1'b0, size_word, 1'b0, make_addr(t, 5, 0), 0));
        end
      end
      send_cmd(make_cmd(1'b0, 1'b0, size_word, 1'b0, make_addr(t, 8'hee, 0), $urandom()));
      send_cmd(make_cmd(1'b1, 1'b0, size_word, 1'b0, make_addr(t, 8'hee, 0), 0));
    end
    drain();

    // LR/SC pairs, then each way of losing the reservation
    test_name = "lr_sc";
    for (t = 0; t < 2; t++) begin
      a = make_addr(t, 9, 0);
      send_cmd(make_cmd(1'b1, 1'b1, size_word, 1'b0, a, 0));
      send_cmd(make_cmd(1'b0, 1'b1, size_word, 1'b0, a, 32'h1234_5678));
      send_cmd(make_cmd(1'b1, 1'b0, size_word, 1'b0, a, 0));
      send_cmd(make_cmd(1'b1, 1'b1, size_word, 1'b0, a, 0));
      send_cmd(make_cmd(1'b0, 1'b0, size_word, 1'b0, a, 32'h0bad_f00d));
      send_cmd(make_cmd(1'b0, 1'b1, size_word, 1'b0, a, 32'hdead_beef));
      send_cmd(make_cmd(1'b1, 1'b1, size_word, 1'b0, a, 0));
      pulse_commit(1'b1);
      send_cmd(make_cmd(1'b0, 1'b1, size_word, 1'b0, a, 32'h5555_aaaa));
      send_cmd(make_cmd(1'b1, 1'b1, size_word, 1'b0, a, 0));
      pulse_commit(1'b0);
      send_cmd(make_cmd(1'b0, 1'b1, size_word, 1'b0, a, 32'haaaa_5555));
      send_cmd(make_cmd(1'b1, 1'b0, size_word, 1'b0, a, 0));
    end
    drain();

    // Mixed traffic with write-back stalls
    test_name = "random";
    stall_en  = 1'b1;
    for (int i = 0; i < 300; i++) begin
      t   = int'($urandom_range(1));
      sz  = int'($urandom_range(2));
      ex  = ($urandom_range(7) == 0);
      off = (sz == 0) ? int'($urandom_range(3)) : (sz == 1) ? 2 * int'($urandom_range(1)) : 0;
      if (ex) begin
        sz  = 2;
        off = 0;
      end
      a = make_addr(t, int'($urandom_range(15)), off);
      send_cmd(make_cmd(1'($urandom_range(1)), ex, lsu_size_e'(2'(sz)),
                        1'($urandom_range(1)), a, $urandom()));
      if ($urandom_range(31) == 0) begin
        pulse_commit(1'($urandom_range(1)));
      end
    end
    drain();
    stall_en = 1'b0;
    check_idle("drained");

    $display("errors: write-back %0d, target command %0d, other %0d",
             wb_errs, cmd_errs, other_errs);
    if (wb_errs + cmd_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
